/* hw/looper_macros.svh */
`ifndef LOOPER_MACROS_SVH
`define LOOPER_MACROS_SVH

// ==================================================
// Dispatcher sizes
// ==================================================

// Cores fed by the dispatcher
`define LOOPER_N_CORE 4

// Grid dimensions walked per job
`define LOOPER_VDIM 2

// Bits in one grid coordinate
`define LOOPER_WORK_BW 12

// Undone blocks a single core may hold
`define LOOPER_MAX_PENDING 3

`endif

/* hw/looper_pkg.sv */
`include "looper_macros.svh"

package looper_pkg;

	// ==================================================
	// Grid values
	// ==================================================

	// One coordinate of the block grid
	typedef logic [`LOOPER_WORK_BW-1:0] work_t;

	// Step, end or offset across all dimensions, dim 0 in the low slice
	typedef work_t [`LOOPER_VDIM-1:0] grid_vec_t;

	// One bit per core
	typedef logic [`LOOPER_N_CORE-1:0] core_mask_t;

	// Per-core dispatch offsets
	typedef grid_vec_t [`LOOPER_N_CORE-1:0] core_ofs_t;

	// ==================================================
	// State machines
	// ==================================================

	typedef enum logic [1:0] {G_IDLE, G_RUN, G_LAST_WAIT} grid_state_t;

	typedef enum logic [1:0] {J_IDLE, J_ISSUE, J_DRAIN, J_ACK} job_state_t;

endpackage

/* hw/ofs_if.sv */
`timescale 1ns/1ps

interface ofs_if;

	import looper_pkg::*;

	// Offset valid from the grid stage
	logic rdy;
	// Taken by the looper, transfer on rdy && ack
	logic ack;
	// Current grid point
	grid_vec_t ofs;
	// High while the final grid point is presented
	logic last;

	// Grid stage side
	modport src (output rdy, output ofs, output last, input ack);

	// Looper side
	modport dst (input rdy, input ofs, input last, output ack);

endinterface

/* hw/grid_offset_stage.sv */
`timescale 1ns/1ps
`include "looper_macros.svh"

module grid_offset_stage (
	input  logic                  i_clk,
	input  logic                  i_arst_n,
	input  logic                  i_start,
	input  looper_pkg::grid_vec_t i_step,
	input  looper_pkg::grid_vec_t i_end,
	ofs_if.src                    o_ofs
);

	import looper_pkg::*;

	localparam int VDIM = `LOOPER_VDIM;
	localparam int WBW  = `LOOPER_WORK_BW;

	grid_state_t state_r;
	grid_vec_t   cnt_r;
	grid_vec_t   cnt_nx;
	// One extra bit so a sum near the top of the range still compares right
	logic [WBW:0]    sum  [VDIM];
	logic [WBW:0]    nsum [VDIM];
	logic [VDIM-1:0] wrap;
	logic [VDIM-1:0] nwrap;
	logic [VDIM-1:0] zwrap;
	logic            xfer;

	// ==================================================
	// Offset stream
	// ==================================================

	assign o_ofs.rdy  = (state_r != G_IDLE);
	assign o_ofs.last = (state_r == G_LAST_WAIT);
	assign o_ofs.ofs  = cnt_r;
	assign xfer       = o_ofs.rdy && o_ofs.ack;

	// ==================================================
	// Next raster point
	// ==================================================

	always_comb begin : next_point
		logic carry;
		carry = 1'b1;
		for (int d = 0; d < VDIM; d++) begin
			sum[d]  = {1'b0, cnt_r[d]} + {1'b0, i_step[d]};
			wrap[d] = (sum[d] >= {1'b0, i_end[d]});
			// Dim 0 always advances, higher dims only on carry
			if (!carry) begin
				cnt_nx[d] = cnt_r[d];
			end else if (wrap[d]) begin
				cnt_nx[d] = '0;
			end else begin
				cnt_nx[d] = sum[d][WBW-1:0];
			end
			carry = carry & wrap[d];
			// Would the point after next wrap here
			nsum[d]  = {1'b0, cnt_nx[d]} + {1'b0, i_step[d]};
			nwrap[d] = (nsum[d] >= {1'b0, i_end[d]});
			// Origin is already the last point when step covers end
			zwrap[d] = (i_step[d] >= i_end[d]);
		end
	end

	// ==================================================
	// Walk FSM
	// ==================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_r <= G_IDLE;
			cnt_r   <= '0;
		end else begin
			case (state_r)
				G_IDLE: begin
					// Origin shows up the cycle after start
					if (i_start) begin
						cnt_r   <= '0;
						state_r <= (&zwrap) ? G_LAST_WAIT : G_RUN;
					end
				end
				G_RUN: begin
					if (xfer) begin
						cnt_r <= cnt_nx;
						if (&nwrap) begin
							state_r <= G_LAST_WAIT;
						end
					end
				end
				G_LAST_WAIT: begin
					// Every dim wraps here, counter returns to zero
					if (xfer) begin
						cnt_r   <= cnt_nx;
						state_r <= G_IDLE;
					end
				end
				default: begin
					state_r <= G_IDLE;
				end
			endcase
		end
	end

endmodule

/* hw/pending_semaphore.sv */
`timescale 1ns/1ps
`include "looper_macros.svh"

module pending_semaphore #(
	parameter int P_MAX = `LOOPER_MAX_PENDING
) (
	input  logic i_clk,
	input  logic i_arst_n,
	input  logic i_inc,
	input  logic i_dec,
	output logic o_full,
	output logic o_empty
);

	// Enough bits to count 0 through P_MAX
	localparam int CW = $clog2(P_MAX + 1);

	logic [CW-1:0] cnt_r;

	// ==================================================
	// Outstanding block count
	// ==================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt_r <= '0;
		end else begin
			// Inc and dec together cancel
			if (i_inc && !i_dec) begin
				cnt_r <= cnt_r + 1'b1;
			end else if (i_dec && !i_inc) begin
				cnt_r <= cnt_r - 1'b1;
			end
		end
	end

	// Full blocks the next dispatch to this core
	assign o_full  = (cnt_r == CW'(P_MAX));
	assign o_empty = (cnt_r == '0);

endmodule

/* hw/block_looper.sv */
`timescale 1ns/1ps
`include "looper_macros.svh"

module block_looper (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_src_rdy,
	output logic                   o_src_ack,
	output logic                   o_start,
	ofs_if.dst                     i_ofs,
	output looper_pkg::core_mask_t o_bofs_rdy,
	input  looper_pkg::core_mask_t i_bofs_ack,
	output looper_pkg::core_ofs_t  o_bofss,
	input  looper_pkg::core_mask_t i_blkdone
);

	import looper_pkg::*;

	localparam int N_CORE = `LOOPER_N_CORE;

	job_state_t state_r;
	logic       start_r;
	// Slot k holds an offset not yet taken by core k
	core_mask_t slot_vld_r;
	core_mask_t can_send;
	core_mask_t sel;
	core_mask_t load;
	core_mask_t core_xfer;
	core_mask_t sem_full;
	core_mask_t sem_empty;
	logic       ofs_xfer;
	logic       all_idle;

	// ==================================================
	// Slot selection
	// ==================================================

	assign can_send = ~slot_vld_r;

	// Highest empty slot wins
	always_comb begin : msb_pick
		logic found;
		found = 1'b0;
		sel   = '0;
		for (int k = N_CORE - 1; k >= 0; k--) begin
			if (can_send[k] && !found) begin
				sel[k] = 1'b1;
				found  = 1'b1;
			end
		end
	end

	// Take an offset only while some slot can hold it
	assign i_ofs.ack = (state_r == J_ISSUE) && (|can_send);
	assign ofs_xfer  = i_ofs.rdy && i_ofs.ack;
	assign load      = sel & {N_CORE{ofs_xfer}};

	// Core sees its slot only when it has room for another block
	assign o_bofs_rdy = slot_vld_r & ~sem_full;
	assign core_xfer  = o_bofs_rdy & i_bofs_ack;

	// Job done once nothing is queued or outstanding
	assign all_idle = !(|slot_vld_r) && (&sem_empty);

	assign o_start   = start_r;
	assign o_src_ack = (state_r == J_ACK);

	// ==================================================
	// Job FSM
	// ==================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_r <= J_IDLE;
			start_r <= 1'b0;
		end else begin
			// Start is a one-cycle pulse
			start_r <= 1'b0;
			case (state_r)
				J_IDLE: begin
					if (i_src_rdy) begin
						start_r <= 1'b1;
						state_r <= J_ISSUE;
					end
				end
				J_ISSUE: begin
					if (ofs_xfer && i_ofs.last) begin
						state_r <= J_DRAIN;
					end
				end
				J_DRAIN: begin
					// Wait for every core to report its blocks
					if (all_idle) begin
						state_r <= J_ACK;
					end
				end
				J_ACK: begin
					state_r <= J_IDLE;
				end
				default: begin
					state_r <= J_IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Dispatch slots
	// ==================================================

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			slot_vld_r <= '0;
			o_bofss    <= '0;
		end else begin
			for (int k = 0; k < N_CORE; k++) begin
				// Load only hits an empty slot, so never clashes with a take
				if (load[k]) begin
					slot_vld_r[k] <= 1'b1;
					o_bofss[k]    <= i_ofs.ofs;
				end else if (core_xfer[k]) begin
					slot_vld_r[k] <= 1'b0;
				end
			end
		end
	end

	// Pending counters, bumped on take and dropped on done
	genvar g;
	generate
		for (g = 0; g < N_CORE; g++) begin : g_sem
			pending_semaphore #(
				.P_MAX(`LOOPER_MAX_PENDING)
			) u_sem (
				.i_clk   (i_clk),
				.i_arst_n(i_arst_n),
				.i_inc   (core_xfer[g]),
				.i_dec   (i_blkdone[g]),
				.o_full  (sem_full[g]),
				.o_empty (sem_empty[g])
			);
		end
	endgenerate

endmodule

/* hw/block_dispatch_top.sv */
`timescale 1ns/1ps

module block_dispatch_top (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	// Host job handshake
	input  logic                   i_src_rdy,
	output logic                   o_src_ack,
	input  looper_pkg::grid_vec_t  i_bgrid_step,
	input  looper_pkg::grid_vec_t  i_bgrid_end,
	// Per-core block dispatch
	output looper_pkg::core_mask_t o_bofs_rdy,
	input  looper_pkg::core_mask_t i_bofs_ack,
	output looper_pkg::core_ofs_t  o_bofss,
	// Done strobes, one per finished block
	input  looper_pkg::core_mask_t i_blkdone
);

	// ==================================================
	// Internal links
	// ==================================================

	// Grid stage to looper offset stream
	ofs_if u_ofs_bus ();

	// Looper kicks the grid walk for each job
	logic start;

	// ==================================================
	// Grid walk
	// ==================================================

	// Step and end stay stable until the job is acked
	grid_offset_stage u_grid (
		.i_clk   (i_clk),
		.i_arst_n(i_arst_n),
		.i_start (start),
		.i_step  (i_bgrid_step),
		.i_end   (i_bgrid_end),
		.o_ofs   (u_ofs_bus.src)
	);

	// ==================================================
	// Core dispatch
	// ==================================================

	block_looper u_looper (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_src_rdy (i_src_rdy),
		.o_src_ack (o_src_ack),
		.o_start   (start),
		.i_ofs     (u_ofs_bus.dst),
		.o_bofs_rdy(o_bofs_rdy),
		.i_bofs_ack(i_bofs_ack),
		.o_bofss   (o_bofss),
		.i_blkdone (i_blkdone)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real P_PERIOD     = 4.0,
	parameter int  P_RST_CYCLES = 4
) (
	output logic o_clk,
	output logic o_arst_n
);

	// Free-running clock, first rise half a period in
	initial begin
		o_clk = 1'b0;
		forever #(P_PERIOD / 2.0) o_clk = ~o_clk;
	end

	// Reset low for the first cycles, released on a rising edge
	initial begin
		o_arst_n = 1'b0;
		repeat (P_RST_CYCLES) @(posedge o_clk);
		o_arst_n <= 1'b1;
	end

endmodule

/* tb/block_dispatch_tb.sv */
`timescale 1ns/1ps
`include "looper_macros.svh"

module block_dispatch_tb;

	import looper_pkg::*;

	localparam int NC   = `LOOPER_N_CORE;
	localparam int VD   = `LOOPER_VDIM;
	localparam int MAXP = `LOOPER_MAX_PENDING;
	localparam int TMO  = 4000;

	logic       clk;
	logic       arst_n;
	logic       src_rdy;
	logic       src_ack;
	grid_vec_t  bgrid_step;
	grid_vec_t  bgrid_end;
	core_mask_t bofs_rdy;
	core_mask_t bofs_ack;
	core_ofs_t  bofss;
	core_mask_t blkdone;

	// Scoreboard and core model state
	grid_vec_t   exp_q[$];
	grid_vec_t   rcv_q[$];
	int          seen_cnt [bit [VD*`LOOPER_WORK_BW-1:0]];
	int          pend [NC];
	int          max_pend [NC];
	int          done_wait [NC];
	int          stall_cnt [NC];
	int          ack_delay [NC];
	core_mask_t  hold_done;
	core_mask_t  held_vld;
	core_ofs_t   held_ofs;
	logic        done_rand;
	int          cyc;
	int          ack_cnt;
	int          ack_cyc;
	int          last_done_cyc;
	int          stall_seen;
	int          err_cnt;
	int          err_mark;
	int          pass_cnt;
	int          fail_cnt;
	logic        timed_out;
	logic [31:0] rng;
	string       cur_test;

	tb_clock_gen u_clk (
		.o_clk   (clk),
		.o_arst_n(arst_n)
	);

	block_dispatch_top uut (
		.i_clk       (clk),
		.i_arst_n    (arst_n),
		.i_src_rdy   (src_rdy),
		.o_src_ack   (src_ack),
		.i_bgrid_step(bgrid_step),
		.i_bgrid_end (bgrid_end),
		.o_bofs_rdy  (bofs_rdy),
		.i_bofs_ack  (bofs_ack),
		.o_bofss     (bofss),
		.i_blkdone   (blkdone)
	);

	// ==================================================
	// Helpers
	// ==================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic expect_equal(input string what, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
				cur_test, what, exp_v, act_v);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("Timeout in %s: %s never happened", cur_test, what);
		timed_out = 1'b1;
	endtask

	// Name the test and set how the core models behave
	task automatic begin_test(input string name, input logic rnd, input core_mask_t hold,
			input core_mask_t stall, input int len);
		@(negedge clk);
		cur_test  = name;
		err_mark  = err_cnt;
		done_rand = rnd;
		hold_done = hold;
		for (int k = 0; k < NC; k++) begin
			ack_delay[k] = stall[k] ? len + k : 0;
		end
	endtask

	task automatic end_test();
		if (err_cnt == err_mark && !timed_out) begin
			pass_cnt = pass_cnt + 1;
			$display("%s: ok", cur_test);
		end else begin
			fail_cnt = fail_cnt + 1;
			$display("%s: FAILED with %0d errors", cur_test, err_cnt - err_mark);
		end
	endtask

	// ==================================================
	// Core models
	// ==================================================

	always @(posedge clk) begin : core_models
		core_mask_t ack_nx;
		core_mask_t done_nx;
		logic       xfer;
		ack_nx  = bofs_ack;
		done_nx = '0;
		if (arst_n) begin
			cyc = cyc + 1;
			if (src_ack) begin
				ack_cnt = ack_cnt + 1;
				ack_cyc = cyc;
			end
			for (int k = 0; k < NC; k++) begin
				// Done strobe driven last cycle lands now
				if (blkdone[k]) begin
					pend[k]       = pend[k] - 1;
					last_done_cyc = cyc;
				end
				xfer = bofs_rdy[k] && bofs_ack[k];
				// Offset left waiting must stay put until taken
				if (held_vld[k]) begin
					expect_equal("held rdy", 1, 32'(bofs_rdy[k]));
					expect_equal("held offset", 32'(held_ofs[k]), 32'(bofss[k]));
					stall_seen = stall_seen + 1;
				end
				if (xfer) begin
					rcv_q.push_back(bofss[k]);
					seen_cnt[bofss[k]] = seen_cnt.exists(bofss[k]) ?
						seen_cnt[bofss[k]] + 1 : 1;
					pend[k] = pend[k] + 1;
					if (pend[k] > max_pend[k]) begin
						max_pend[k] = pend[k];
					end
					if (pend[k] > MAXP) begin
						expect_equal("pending limit", MAXP, pend[k]);
					end
					stall_cnt[k] = 0;
				end
				held_vld[k] = bofs_rdy[k] && !xfer;
				held_ofs[k] = bofss[k];
				// Ack at once or after the core's stall time
				if (ack_delay[k] == 0) begin
					ack_nx[k] = 1'b1;
				end else if (xfer) begin
					ack_nx[k] = 1'b0;
				end else if (bofs_rdy[k]) begin
					stall_cnt[k] = stall_cnt[k] + 1;
					ack_nx[k]    = (stall_cnt[k] >= ack_delay[k]);
				end
				// At most one done per cycle spaced by a random or zero gap
				if (!hold_done[k] && pend[k] > 0) begin
					if (done_wait[k] > 0) begin
						done_wait[k] = done_wait[k] - 1;
					end else begin
						done_nx[k]   = 1'b1;
						rng          = xorshift32(rng);
						done_wait[k] = done_rand ? int'(rng % 4) : 0;
					end
				end
			end
		end
		bofs_ack <= ack_nx;
		blkdone  <= done_nx;
	end

	// ==================================================
	// Job sequencing
	// ==================================================

	task automatic start_job(input grid_vec_t step, input grid_vec_t gend);
		grid_vec_t pt;
		logic      wrapped;
		@(negedge clk);
		rcv_q.delete();
		seen_cnt.delete();
		exp_q.delete();
		ack_cnt    = 0;
		stall_seen = 0;
		for (int k = 0; k < NC; k++) begin
			max_pend[k] = 0;
		end
		// Expected raster order with dim 0 fastest
		pt      = '0;
		wrapped = 1'b0;
		while (!wrapped) begin
			exp_q.push_back(pt);
			wrapped = 1'b1;
			for (int d = 0; d < VD && wrapped; d++) begin
				if (int'(pt[d]) + int'(step[d]) < int'(gend[d])) begin
					pt[d]   = pt[d] + step[d];
					wrapped = 1'b0;
				end else begin
					pt[d] = '0;
				end
			end
		end
		@(posedge clk);
		src_rdy    <= 1'b1;
		bgrid_step <= step;
		bgrid_end  <= gend;
	endtask

	task automatic wait_job_ack();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n = n + 1;
		end while (!src_ack && n < TMO);
		if (!src_ack) begin
			note_timeout("job ack");
			return;
		end
		src_rdy <= 1'b0;
		@(posedge clk);
		expect_equal("ack width", 0, 32'(src_ack));
		@(negedge clk);
		expect_equal("ack count", 1, ack_cnt);
		expect_equal("ack after last done", 1, 32'(ack_cyc > last_done_cyc));
		expect_equal("blocks at ack", exp_q.size(), rcv_q.size());
		for (int k = 0; k < NC; k++) begin
			expect_equal($sformatf("undone blocks core %0d", k), 0, pend[k]);
		end
	endtask

	// Each grid point exactly once across all cores
	task automatic verify_offsets();
		foreach (exp_q[i]) begin
			expect_equal($sformatf("times seen offset %h", exp_q[i]), 1,
				seen_cnt.exists(exp_q[i]) ? seen_cnt[exp_q[i]] : 0);
		end
	endtask

	task automatic run_job(input grid_vec_t step, input grid_vec_t gend);
		start_job(step, gend);
		wait_job_ack();
		if (!timed_out) begin
			verify_offsets();
		end
	endtask

	// ==================================================
	// Tests
	// ==================================================

	task automatic reset_quiet();
		begin_test("reset_quiet", 1'b0, '0, '0, 0);
		repeat (16) begin
			@(posedge clk);
			expect_equal("src ack", 0, 32'(src_ack));
			expect_equal("core rdy", 0, 32'(bofs_rdy));
			expect_equal("core offsets nonzero", 0, 32'(|bofss));
		end
	endtask

	task automatic grid_2d_basic();
		begin_test("grid_2d_basic", 1'b0, '0, '0, 0);
		run_job({12'd1, 12'd1}, {12'd3, 12'd5});
	endtask

	task automatic ragged_end();
		grid_vec_t step;
		grid_vec_t gend;
		int        top_v;
		int        n_exp;
		begin_test("ragged_end", 1'b1, '0, '0, 0);
		step = {12'd5, 12'd3};
		gend = {12'd12, 12'd10};
		run_job(step, gend);
		if (timed_out) begin
			return;
		end
		n_exp = 1;
		for (int d = 0; d < VD; d++) begin
			top_v = 0;
			foreach (rcv_q[i]) begin
				if (int'(rcv_q[i][d]) > top_v) begin
					top_v = int'(rcv_q[i][d]);
				end
			end
			// Highest step multiple below end
			expect_equal($sformatf("top offset dim %0d", d),
				((int'(gend[d]) - 1) / int'(step[d])) * int'(step[d]), top_v);
			n_exp = n_exp * ((int'(gend[d]) + int'(step[d]) - 1) / int'(step[d]));
		end
		expect_equal("block count", n_exp, rcv_q.size());
	endtask

	task automatic pending_limit();
		int n;
		int quiet;
		int last;
		// Only the top core reports done until released
		begin_test("pending_limit", 1'b0, 4'b0111, '0, 0);
		start_job({12'd1, 12'd1}, {12'd4, 12'd8});
		n     = 0;
		quiet = 0;
		last  = 0;
		while (quiet < 20 && n < TMO) begin
			@(negedge clk);
			n     = n + 1;
			quiet = (rcv_q.size() == last) ? quiet + 1 : 0;
			last  = rcv_q.size();
		end
		if (quiet < 20) begin
			note_timeout("stream stall on full cores");
			return;
		end
		for (int k = 0; k < NC - 1; k++) begin
			expect_equal($sformatf("peak pending core %0d", k), MAXP, max_pend[k]);
		end
		expect_equal("ack while held", 0, ack_cnt);
		expect_equal("blocks held back", 1, 32'(rcv_q.size() < exp_q.size()));
		hold_done = '0;
		wait_job_ack();
		if (!timed_out) begin
			verify_offsets();
		end
	endtask

	task automatic ack_stall();
		begin_test("ack_stall", 1'b1, '0, 4'b1010, 5);
		run_job({12'd1, 12'd2}, {12'd5, 12'd12});
		expect_equal("stall cycles seen", 1, 32'(stall_seen > 0));
	endtask

	task automatic back_to_back();
		begin_test("back_to_back", 1'b1, '0, 4'b0100, 3);
		run_job({12'd3, 12'd2}, {12'd9, 12'd7});
		if (timed_out) begin
			return;
		end
		run_job({12'd1, 12'd4}, {12'd2, 12'd16});
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin : main
		int n;
		src_rdy       <= 1'b0;
		bgrid_step    <= '0;
		bgrid_end     <= '0;
		bofs_ack      <= '0;
		blkdone       <= '0;
		hold_done     = '0;
		held_vld      = '0;
		held_ofs      = '0;
		done_rand     = 1'b0;
		timed_out     = 1'b0;
		rng           = 32'h8b020162;
		cur_test      = "startup";
		n = 0;
		while (!arst_n && n < 100) begin
			@(posedge clk);
			n = n + 1;
		end
		if (!arst_n) begin
			note_timeout("reset release");
		end
		for (int t = 0; t < 6 && !timed_out; t++) begin
			case (t)
				0: reset_quiet();
				1: grid_2d_basic();
				2: ragged_end();
				3: pending_limit();
				4: ack_stall();
				default: back_to_back();
			endcase
			end_test();
		end
		$display("Summary: %0d tests passed, %0d tests failed, %0d errors",
			pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0 && !timed_out) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* block_dispatch.f */
+incdir+hw
hw/looper_pkg.sv
hw/ofs_if.sv
hw/grid_offset_stage.sv
hw/pending_semaphore.sv
hw/block_looper.sv
hw/block_dispatch_top.sv
tb/tb_clock_gen.sv
tb/block_dispatch_tb.sv

/* Makefile */
# Verilator flow for the block dispatcher

VERILATOR ?= verilator
TOP       ?= block_dispatch_tb
FILELIST  ?= block_dispatch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
